// File: include/frame_settings.svh
`ifndef FRAME_SETTINGS_SVH
`define FRAME_SETTINGS_SVH

// frame geometry
`define FRAME_WIDTH      640                           // pixels per line
`define FRAME_HEIGHT     360                           // lines per frame
`define FRAME_DEPTH      230400                        // width times height entries

// data widths
`define COLOR_BITS       4                             // colour index width
`define BRUSH_SIZE_BITS  3                             // brush size 0 to 7

// stage latencies in clk_25mhz cycles
`define HIT_LATENCY      1                             // brush_hit output register
`define STORE_LATENCY    2                             // memory read then output register
`define PALETTE_LATENCY  1                             // palette output register

// pixel strobe to rgb strobe
`define PIPE_LATENCY     (`HIT_LATENCY + `STORE_LATENCY + `PALETTE_LATENCY)

`endif

// File: hdl/display_pkg.sv
`include "frame_settings.svh"

package display_pkg;

    typedef logic [9:0] hcount_t;                          // 0 to 1023, frame uses 0 to 639
    typedef logic [8:0] vcount_t;                          // 0 to 511, frame uses 0 to 359

    // hcount + 640 * vcount
    typedef logic [$clog2(`FRAME_DEPTH)-1:0] frame_addr_t;

    // colour opcodes held in the frame store
    typedef enum logic [`COLOR_BITS-1:0] {
        BLACK   = 0,
        WHITE   = 1,
        RED     = 2,
        GREEN   = 3,
        BLUE    = 4,
        CYAN    = 5,
        MAGENTA = 6,
        YELLOW  = 7,
        GRAY    = 8                                        // 9 to 15 unnamed, shown white
    } color_e;

    typedef logic [7:0] channel_t;                         // one 8-bit colour channel

endpackage

// File: hdl/brush_pkg.sv
`include "frame_settings.svh"

package brush_pkg;

    typedef logic [`BRUSH_SIZE_BITS-1:0] brush_size_t;     // switch setting 0 to 7

    // radius is 2*size + 1 so 1 to 15
    typedef logic [4:0] radius_t;

    // dx^2 + dy^2 over the whole frame stays below 2^20
    typedef logic [20:0] dist_sq_t;

endpackage

// File: hdl/brush_hit.sv
`timescale 1ns/1ps
`include "frame_settings.svh"

module brush_hit (
    input  logic                     clk_25mhz,
    input  logic                     reset_SD_card,
    input  logic                     pixel_valid,    // one-cycle pixel strobe
    input  logic                     draw,           // paint enable with the strobe
    input  display_pkg::hcount_t     hcount,
    input  display_pkg::vcount_t     vcount,
    input  display_pkg::hcount_t     brush_x,        // brush centre
    input  display_pkg::vcount_t     brush_y,
    input  display_pkg::color_e      brush_color,
    input  brush_pkg::brush_size_t   brush_size,
    output logic                     hit_valid,      // pixel strobe one cycle later
    output logic                     hit,            // paint this pixel
    output display_pkg::frame_addr_t hit_addr,
    output display_pkg::color_e      hit_color
);

    brush_pkg::radius_t       radius;               // 2*size + 1
    brush_pkg::dist_sq_t      radius_sq;
    display_pkg::hcount_t     dx_abs;               // |hcount - brush_x|
    display_pkg::vcount_t     dy_abs;               // |vcount - brush_y|
    brush_pkg::dist_sq_t      dist_sq;
    logic                     in_disk;
    logic                     in_frame;
    display_pkg::frame_addr_t pixel_addr;

    assign radius    = {1'b0, brush_size, 1'b1};
    assign radius_sq = brush_pkg::dist_sq_t'(radius) * brush_pkg::dist_sq_t'(radius);

    // unsigned differences so the squares never see a sign
    assign dx_abs = (hcount >= brush_x) ? hcount - brush_x : brush_x - hcount;
    assign dy_abs = (vcount >= brush_y) ? vcount - brush_y : brush_y - vcount;

    assign dist_sq = brush_pkg::dist_sq_t'(dx_abs) * brush_pkg::dist_sq_t'(dx_abs)
                   + brush_pkg::dist_sq_t'(dy_abs) * brush_pkg::dist_sq_t'(dy_abs);
    assign in_disk = (dist_sq <= radius_sq);         // edge of the circle counts as inside

    assign in_frame = (hcount < display_pkg::hcount_t'(`FRAME_WIDTH))
                   && (vcount < display_pkg::vcount_t'(`FRAME_HEIGHT));

    assign pixel_addr = display_pkg::frame_addr_t'(hcount)
                      + display_pkg::frame_addr_t'(vcount)
                      * display_pkg::frame_addr_t'(`FRAME_WIDTH);

    always_ff @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            hit_valid <= 1'b0;
            hit       <= 1'b0;
        end else begin
            hit_valid <= pixel_valid && in_frame;    // off-frame pixels vanish here
            hit       <= pixel_valid && in_frame && draw && in_disk;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (pixel_valid) begin
            hit_addr  <= pixel_addr;
            hit_color <= brush_color;                // colour captured with the pixel
        end
    end

endmodule

// File: hdl/frame_store.sv
`timescale 1ns/1ps
`include "frame_settings.svh"

module frame_store (
    input  logic                     clk_25mhz,
    input  logic                     reset_SD_card,
    input  logic                     hit_valid,      // pixel strobe from brush stage
    input  display_pkg::frame_addr_t addr,           // shared pixel address
    input  logic                     hit1,           // brush 1 covers the pixel
    input  display_pkg::color_e      color1,
    input  logic                     hit2,           // brush 2 covers the pixel
    input  display_pkg::color_e      color2,
    output logic                     rd_valid,       // hit_valid two cycles later
    output display_pkg::color_e      rd_color        // colour stored before this write
);

    display_pkg::color_e mem [`FRAME_DEPTH];         // one index per pixel

    display_pkg::color_e wr_color;                   // merged brush colour
    logic                wr_en;
    logic                valid_q;                    // strobe beside the raw read
    display_pkg::color_e rd_data_q;                  // raw memory read

    // blank canvas at configuration
    initial begin
        for (int i = 0; i < `FRAME_DEPTH; i++) begin
            mem[i] = display_pkg::BLACK;
        end
    end

    // single write port, brush 2 on top
    assign wr_en    = hit_valid && (hit1 || hit2);
    assign wr_color = hit2 ? color2 : color1;

    // read-first port, old entry comes out while the new one goes in
    always_ff @(posedge clk_25mhz) begin
        if (wr_en) begin
            mem[addr] <= wr_color;
        end
        rd_data_q <= mem[addr];
    end

    // output register after the memory
    always_ff @(posedge clk_25mhz) begin
        rd_color <= rd_data_q;
    end

    // strobe follows the data through both registers
    always_ff @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            valid_q  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            valid_q  <= hit_valid;
            rd_valid <= valid_q;
        end
    end

endmodule

// File: hdl/palette_lookup.sv
`timescale 1ns/1ps

module palette_lookup (
    input  logic                  clk_25mhz,
    input  logic                  reset_SD_card,
    input  logic                  rd_valid,          // colour index strobe
    input  display_pkg::color_e   rd_color,
    output logic                  rgb_valid,
    output display_pkg::channel_t red,
    output display_pkg::channel_t green,
    output display_pkg::channel_t blue
);

    display_pkg::channel_t red_next;
    display_pkg::channel_t green_next;
    display_pkg::channel_t blue_next;

    always_comb begin
        case (rd_color)
            display_pkg::BLACK:   {red_next, green_next, blue_next} = 24'h00_00_00;
            display_pkg::WHITE:   {red_next, green_next, blue_next} = 24'hff_ff_ff;
            display_pkg::RED:     {red_next, green_next, blue_next} = 24'hff_00_00;
            display_pkg::GREEN:   {red_next, green_next, blue_next} = 24'h00_ff_00;
            display_pkg::BLUE:    {red_next, green_next, blue_next} = 24'h00_00_ff;
            display_pkg::CYAN:    {red_next, green_next, blue_next} = 24'h00_ff_ff;
            display_pkg::MAGENTA: {red_next, green_next, blue_next} = 24'hff_00_ff;
            display_pkg::YELLOW:  {red_next, green_next, blue_next} = 24'hff_ff_00;
            display_pkg::GRAY:    {red_next, green_next, blue_next} = 24'h80_80_80;
            default:              {red_next, green_next, blue_next} = 24'hff_ff_ff; // unnamed
        endcase
    end

    always_ff @(posedge clk_25mhz) begin
        if (reset_SD_card) begin
            rgb_valid <= 1'b0;
            red       <= '0;
            green     <= '0;
            blue      <= '0;
        end else begin
            rgb_valid <= rd_valid;
            red       <= rd_valid ? red_next : '0;   // black between strobes
            green     <= rd_valid ? green_next : '0;
            blue      <= rd_valid ? blue_next : '0;
        end
    end

endmodule

// File: hdl/paint_frame_top.sv
`timescale 1ns/1ps

module paint_frame_top (
    input  logic                   clk_25mhz,
    input  logic                   reset_SD_card,     // clears the pipeline only
    input  logic                   pixel_valid,
    input  logic                   draw,
    input  display_pkg::hcount_t   hcount,
    input  display_pkg::vcount_t   vcount,
    input  display_pkg::hcount_t   brush1_x,
    input  display_pkg::vcount_t   brush1_y,
    input  display_pkg::color_e    brush1_color,
    input  brush_pkg::brush_size_t brush1_size,
    input  display_pkg::hcount_t   brush2_x,
    input  display_pkg::vcount_t   brush2_y,
    input  display_pkg::color_e    brush2_color,
    input  brush_pkg::brush_size_t brush2_size,
    output logic                   rgb_valid,         // pixel_valid four cycles later
    output display_pkg::channel_t  red,
    output display_pkg::channel_t  green,
    output display_pkg::channel_t  blue
);

    logic                     hit_valid;             // from brush 1, brush 2 is identical
    display_pkg::frame_addr_t hit_addr;
    logic                     hit1;
    display_pkg::color_e      color1;
    logic                     hit2;
    display_pkg::color_e      color2;
    logic                     rd_valid;
    display_pkg::color_e      rd_color;

    brush_hit i_brush1 (
        .clk_25mhz     (clk_25mhz),
        .reset_SD_card (reset_SD_card),
        .pixel_valid   (pixel_valid),
        .draw          (draw),
        .hcount        (hcount),
        .vcount        (vcount),
        .brush_x       (brush1_x),
        .brush_y       (brush1_y),
        .brush_color   (brush1_color),
        .brush_size    (brush1_size),
        .hit_valid     (hit_valid),
        .hit           (hit1),
        .hit_addr      (hit_addr),
        .hit_color     (color1)
    );

    brush_hit i_brush2 (
        .clk_25mhz     (clk_25mhz),
        .reset_SD_card (reset_SD_card),
        .pixel_valid   (pixel_valid),
        .draw          (draw),
        .hcount        (hcount),
        .vcount        (vcount),
        .brush_x       (brush2_x),
        .brush_y       (brush2_y),
        .brush_color   (brush2_color),
        .brush_size    (brush2_size),
        .hit_valid     (),                           // same strobe as brush 1
        .hit           (hit2),
        .hit_addr      (),                           // same address as brush 1
        .hit_color     (color2)
    );

    frame_store i_frame_store (
        .clk_25mhz     (clk_25mhz),
        .reset_SD_card (reset_SD_card),
        .hit_valid     (hit_valid),
        .addr          (hit_addr),
        .hit1          (hit1),
        .color1        (color1),
        .hit2          (hit2),
        .color2        (color2),
        .rd_valid      (rd_valid),
        .rd_color      (rd_color)
    );

    palette_lookup i_palette (
        .clk_25mhz     (clk_25mhz),
        .reset_SD_card (reset_SD_card),
        .rd_valid      (rd_valid),
        .rd_color      (rd_color),
        .rgb_valid     (rgb_valid),
        .red           (red),
        .green         (green),
        .blue          (blue)
    );

endmodule

// File: verification/tb_paint_frame.sv
`timescale 1ns/1ps
`include "frame_settings.svh"

module tb_paint_frame;

    logic                   clk_25mhz;
    logic                   reset_SD_card;
    logic                   pixel_valid;
    logic                   draw;
    display_pkg::hcount_t   hcount;
    display_pkg::vcount_t   vcount;
    display_pkg::hcount_t   brush1_x;
    display_pkg::vcount_t   brush1_y;
    display_pkg::color_e    brush1_color;
    brush_pkg::brush_size_t brush1_size;
    display_pkg::hcount_t   brush2_x;
    display_pkg::vcount_t   brush2_y;
    display_pkg::color_e    brush2_color;
    brush_pkg::brush_size_t brush2_size;
    logic                   rgb_valid;
    display_pkg::channel_t  red;
    display_pkg::channel_t  green;
    display_pkg::channel_t  blue;

    logic [`COLOR_BITS-1:0] shadow [`FRAME_DEPTH];  // expected frame contents
    logic [23:0]            exp_rgb_q [$];          // palette value per in-frame pixel
    int                     due_q [$];              // cycle at which rgb_valid is due
    int cycle_count  = 0;
    int strobes_sent = 0;                           // every strobe including off-frame ones
    int inframe_sent = 0;
    int rgb_seen     = 0;
    int checks       = 0;
    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int b1_x;                                       // brush settings sent with each strobe
    int b1_y;
    int b1_size;
    int b2_x;
    int b2_y;
    int b2_size;
    logic [3:0] b1_color;
    logic [3:0] b2_color;

    paint_frame_top i_dut (
        .clk_25mhz     (clk_25mhz),
        .reset_SD_card (reset_SD_card),
        .pixel_valid   (pixel_valid),
        .draw          (draw),
        .hcount        (hcount),
        .vcount        (vcount),
        .brush1_x      (brush1_x),
        .brush1_y      (brush1_y),
        .brush1_color  (brush1_color),
        .brush1_size   (brush1_size),
        .brush2_x      (brush2_x),
        .brush2_y      (brush2_y),
        .brush2_color  (brush2_color),
        .brush2_size   (brush2_size),
        .rgb_valid     (rgb_valid),
        .red           (red),
        .green         (green),
        .blue          (blue)
    );

    initial begin
        clk_25mhz = 1'b0;
        forever #20 clk_25mhz = ~clk_25mhz;         // 25 MHz
    end

    always @(posedge clk_25mhz) begin
        cycle_count <= cycle_count + 1;
    end

    // run limit follows the number of strobes sent
    initial begin
        while (cycle_count <= 2 * strobes_sent + 1000) @(negedge clk_25mhz);
        $display("timeout: run stopped at cycle %0d with %0d pixels outstanding",
                 cycle_count, due_q.size());
        $display("Regression failed");
        $finish;
    end

    // disk rule with the edge counted as inside
    function automatic bit in_disk(input int px, input int py, input int cx, input int cy,
                                   input int size);
        int dx;
        int dy;
        int rad;
        dx  = px - cx;
        dy  = py - cy;
        rad = 2 * size + 1;
        return (dx * dx + dy * dy) <= rad * rad;
    endfunction

    function automatic logic [23:0] palette_rgb(input logic [3:0] idx);
        case (idx)
            4'd0:    return 24'h000000;             // black
            4'd2:    return 24'hff0000;             // red
            4'd3:    return 24'h00ff00;             // green
            4'd4:    return 24'h0000ff;             // blue
            4'd5:    return 24'h00ffff;             // cyan
            4'd6:    return 24'hff00ff;             // magenta
            4'd7:    return 24'hffff00;             // yellow
            4'd8:    return 24'h808080;             // gray
            default: return 24'hffffff;             // white and 9 to 15
        endcase
    endfunction

    task automatic compare_channel(input string name, input display_pkg::channel_t got,
                                   input display_pkg::channel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%02h expected 0x%02h at cycle %0d",
                     name, got, exp, cycle_count);
        end
    endtask

    task automatic check_strobe(input logic seen, input bit pending, input int due,
                                input int now);
        if (seen && !pending) begin
            errors++;
            $display("extra rgb_valid at cycle %0d with no pixel outstanding", now);
        end else if (seen && due != now) begin
            errors++;
            $display("rgb_valid came at cycle %0d but the pixel was due at %0d", now, due);
        end else if (!seen && pending && now >= due) begin
            errors++;
            $display("missing rgb_valid for the pixel due at cycle %0d", due);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("%s: saw %0d outputs where %0d were expected", what, got, exp);
        end
    endtask

    // response checker on the falling edge
    always @(negedge clk_25mhz) begin
        logic [23:0] exp_rgb;
        bit          pending;
        int          due;
        if (!reset_SD_card) begin
            pending = (due_q.size() != 0);
            due     = pending ? due_q[0] : 0;
            check_strobe(rgb_valid === 1'b1, pending, due, cycle_count);
            if (rgb_valid === 1'b1) begin
                rgb_seen++;
                if (pending) begin
                    due     = due_q.pop_front();
                    exp_rgb = exp_rgb_q.pop_front();
                    compare_channel("red", red, exp_rgb[23:16]);
                    compare_channel("green", green, exp_rgb[15:8]);
                    compare_channel("blue", blue, exp_rgb[7:0]);
                end
            end else begin
                compare_channel("red", red, 8'h00);         // black between strobes
                compare_channel("green", green, 8'h00);
                compare_channel("blue", blue, 8'h00);
                if (pending && cycle_count >= due) begin
                    due     = due_q.pop_front();  // drop the lost pixel
                    exp_rgb = exp_rgb_q.pop_front();
                end
            end
        end
    end

    // one strobe right after the previous one with the model updated read-first
    task automatic send_pixel(input int h, input int v, input bit d);
        int         addr;
        bit         hit1;
        bit         hit2;
        @(posedge clk_25mhz);
        pixel_valid  <= 1'b1;
        draw         <= d;
        hcount       <= display_pkg::hcount_t'(h);
        vcount       <= display_pkg::vcount_t'(v);
        brush1_x     <= display_pkg::hcount_t'(b1_x);
        brush1_y     <= display_pkg::vcount_t'(b1_y);
        brush1_color <= display_pkg::color_e'(b1_color);
        brush1_size  <= brush_pkg::brush_size_t'(b1_size);
        brush2_x     <= display_pkg::hcount_t'(b2_x);
        brush2_y     <= display_pkg::vcount_t'(b2_y);
        brush2_color <= display_pkg::color_e'(b2_color);
        brush2_size  <= brush_pkg::brush_size_t'(b2_size);
        strobes_sent++;
        if (h < `FRAME_WIDTH && v < `FRAME_HEIGHT) begin
            addr = h + v * `FRAME_WIDTH;
            exp_rgb_q.push_back(palette_rgb(shadow[addr]));  // old colour comes back
            due_q.push_back(cycle_count + `PIPE_LATENCY + 1);
            inframe_sent++;
            hit1 = in_disk(h, v, b1_x, b1_y, b1_size);
            hit2 = in_disk(h, v, b2_x, b2_y, b2_size);
            if (d && (hit1 || hit2)) begin
                shadow[addr] = hit2 ? b2_color : b1_color;    // brush 2 on top
            end
        end
    endtask

    task automatic end_burst();
        @(posedge clk_25mhz);
        pixel_valid <= 1'b0;
        draw        <= 1'b0;
    endtask

    task automatic wait_drain();
        while (due_q.size() != 0) @(negedge clk_25mhz);
        repeat (3) @(negedge clk_25mhz);            // room for a late extra strobe
    endtask

    task automatic sweep(input int x0, input int y0, input int x1, input int y1, input bit d);
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                send_pixel(x, y, d);
            end
        end
    endtask

    task automatic park_brush2();
        b2_x     = 1023;                            // far outside every swept window
        b2_y     = 511;
        b2_size  = 0;
        b2_color = 4'd0;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start_errors);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic test_reset_and_latency();
        int start_errors;
        int seen_before;
        start_errors = errors;
        repeat (3) begin
            @(negedge clk_25mhz);
            compare_channel("red", red, 8'h00);
            compare_channel("green", green, 8'h00);
            compare_channel("blue", blue, 8'h00);
        end
        seen_before = rgb_seen;
        check_count("idle after reset", rgb_seen, 0);
        send_pixel(5, 5, 1'b0);
        end_burst();
        wait_drain();
        check_count("single strobe", rgb_seen - seen_before, 1);
        finish_test("reset and latency", start_errors);
    endtask

    task automatic test_blank_sweep();
        int start_errors;
        int seen_before;
        int sent_before;
        start_errors = errors;
        seen_before  = rgb_seen;
        sent_before  = inframe_sent;
        b1_x     = 630;                             // red disk over the window with draw low
        b1_y     = 355;
        b1_size  = 7;
        b1_color = 4'd2;
        sweep(620, 350, 659, 369, 1'b0);            // crosses both frame edges
        sweep(620, 350, 659, 369, 1'b0);            // second visit shows any stray write
        send_pixel(1023, 511, 1'b0);
        end_burst();
        wait_drain();
        check_count("blank sweep", rgb_seen - seen_before, inframe_sent - sent_before);
        finish_test("blank sweep", start_errors);
    endtask

    task automatic test_brush_sizes();
        int start_errors;
        int r;
        start_errors = errors;
        park_brush2();
        for (int s = 0; s < 8; s++) begin
            r        = 2 * s + 1;
            b1_x     = 40 + int'($urandom % 560);
            b1_y     = 40 + int'($urandom % 280);
            b1_size  = s;
            b1_color = 4'(s + 1);
            sweep(b1_x - r - 2, b1_y - r - 2, b1_x + r + 2, b1_y + r + 2, 1'b1);
            sweep(b1_x - r - 2, b1_y - r - 2, b1_x + r + 2, b1_y + r + 2, 1'b0);
        end
        end_burst();
        wait_drain();
        finish_test("brush sizes", start_errors);
    endtask

    task automatic test_brush_overlap();
        int start_errors;
        start_errors = errors;
        b1_x     = 300;                             // red disk
        b1_y     = 200;
        b1_size  = 4;
        b1_color = 4'd2;
        b2_x     = 310;                             // blue disk over its right side
        b2_y     = 205;
        b2_size  = 4;
        b2_color = 4'd4;
        sweep(288, 188, 322, 217, 1'b1);
        sweep(288, 188, 322, 217, 1'b0);
        end_burst();
        wait_drain();
        finish_test("brush overlap", start_errors);
    endtask

    task automatic test_palette();
        int start_errors;
        start_errors = errors;
        park_brush2();
        b1_y    = 330;
        b1_size = 0;
        for (int i = 0; i < 16; i++) begin
            b1_x     = 100 + 3 * i;                 // only the centre pixel is strobed
            b1_color = 4'(i);
            send_pixel(b1_x, b1_y, 1'b1);
        end
        for (int i = 0; i < 16; i++) begin
            send_pixel(100 + 3 * i, 330, 1'b0);
        end
        end_burst();
        wait_drain();
        finish_test("palette", start_errors);
    endtask

    initial begin
        void'($urandom(32'hf61b_7971));
        for (int i = 0; i < `FRAME_DEPTH; i++) begin
            shadow[i] = '0;                         // memory starts black
        end
        b1_x = 0;
        b1_y = 0;
        b1_size = 0;
        b1_color = 4'd0;
        park_brush2();
        reset_SD_card = 1'b1;
        pixel_valid   = 1'b0;
        draw          = 1'b0;
        hcount        = '0;
        vcount        = '0;
        brush1_x      = '0;
        brush1_y      = '0;
        brush1_color  = display_pkg::BLACK;
        brush1_size   = '0;
        brush2_x      = '0;
        brush2_y      = '0;
        brush2_color  = display_pkg::BLACK;
        brush2_size   = '0;
        repeat (3) @(posedge clk_25mhz);
        reset_SD_card <= 1'b0;
        test_reset_and_latency();
        test_blank_sweep();
        test_brush_sizes();
        test_brush_overlap();
        test_palette();
        $display("tests %0d, failed %0d, checks %0d, errors %0d, strobes %0d",
                 tests_run, tests_failed, checks, errors, strobes_sent);
        if (errors == 0 && tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+include
hdl/display_pkg.sv
hdl/brush_pkg.sv
hdl/brush_hit.sv
hdl/frame_store.sv
hdl/palette_lookup.sv
hdl/paint_frame_top.sv
verification/tb_paint_frame.sv

// File: Makefile
TOP := tb_paint_frame
LOG := sim.log

SOURCES := src.f $(wildcard include/*.svh hdl/*.sv verification/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SOURCES)
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Regression passed" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)
	verilator --lint-only --timing -f src.f --top-module paint_frame_top

clean:
	rm -rf obj_dir $(LOG)
